/* hdl/acr_pkg.sv */
// acr_pkg
// shared constants for the HDMI audio clock regeneration packet path
// and the Wishbone register map.
package acr_pkg;

    // packet header byte HB0 for audio clock regeneration.
    localparam logic [7:0] ACR_PACKET_TYPE = 8'd1;

    // BCH payload and parity widths.
    localparam int HEADER_BITS = 24;
    localparam int SUBPACKET_BITS = 56;
    localparam int ECC_BITS = 8;

    // codeword widths, payload plus parity.
    localparam int HEADER_CODE_BITS = 32;
    localparam int SUBPACKET_CODE_BITS = 64;

    // pixel clocks per data island packet.
    localparam int ISLAND_CYCLES = 32;

    // Wishbone bus widths.
    localparam int WB_ADDR_BITS = 2;
    localparam int WB_DATA_BITS = 32;

    // register word addresses.
    localparam logic [WB_ADDR_BITS-1:0] REG_CTRL = 2'd0;
    localparam logic [WB_ADDR_BITS-1:0] REG_CTS = 2'd1;
    localparam logic [WB_ADDR_BITS-1:0] REG_COUNT = 2'd2;

endpackage

/* hdl/acr_packet.sv */
`timescale 1ns/1ps
// acr_packet
// divides the audio clock into N/128 wraps, measures CTS in pixel clocks
// and forms the ACR packet header and subpacket.
module acr_packet
#(
    parameter real VIDEO_RATE = 74.25e6,
    parameter int AUDIO_RATE = 48000
)
(
    input  logic clk_pixel,
    input  logic clk_audio,
    input  logic rst,
    output logic [acr_pkg::HEADER_BITS-1:0] header,
    output logic [acr_pkg::SUBPACKET_BITS-1:0] sub_packet,
    output logic [19:0] cts,
    output logic cts_update
);
    // N from the recommended tables, falling back to 16*fs/125.
    localparam logic [19:0] N = (AUDIO_RATE % 125 == 0) ? 20'(16 * AUDIO_RATE / 125)
        : (AUDIO_RATE % 225 == 0) ? 20'(32 * AUDIO_RATE / 225)
        : 20'(16 * AUDIO_RATE / 125);
    localparam int WRAP_SAMPLES = int'(N) / 128;
    localparam int WRAP_BITS = $clog2(WRAP_SAMPLES + 1);
    localparam logic [WRAP_BITS-1:0] WRAP_LAST = WRAP_BITS'(WRAP_SAMPLES - 1);
    localparam int CTS_IDEAL = int'(VIDEO_RATE * real'(N) / 128.0 / real'(AUDIO_RATE));
    // room for the audio clock running 10% slow.
    localparam int CTS_BITS = $clog2(int'(real'(CTS_IDEAL) * 1.1));

    logic [WRAP_BITS-1:0] sample_count = '0;
    logic wrap_flag = 1'b0;
    logic wrap_meta;
    logic wrap_sync;
    logic wrap_prev;
    logic wrap_edge;
    logic armed;
    logic [CTS_BITS-1:0] cycle_count;

    // free-running audio divider.
    always_ff @(posedge clk_audio)
    begin
        if (sample_count == WRAP_LAST)
        begin
            sample_count <= '0;
            wrap_flag <= ~wrap_flag;                    // one toggle per wrap.
        end
        else
        begin
            sample_count <= sample_count + 1'b1;
        end
    end

    assign wrap_edge = wrap_sync ^ wrap_prev;

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            wrap_meta <= 1'b0;
            wrap_sync <= 1'b0;
            wrap_prev <= 1'b0;
            armed <= 1'b0;
            cycle_count <= '0;
            cts <= '0;
            cts_update <= 1'b0;
        end
        else
        begin
            wrap_meta <= wrap_flag;                     // two-stage synchronizer.
            wrap_sync <= wrap_meta;
            wrap_prev <= wrap_sync;
            // the first edge after reset only starts a measurement.
            cts_update <= wrap_edge & armed;
            if (wrap_edge)
            begin
                armed <= 1'b1;
                cycle_count <= '0;
                if (armed)
                begin
                    cts <= 20'(cycle_count) + 20'd1;    // cycles between edges.
                end
            end
            else
            begin
                cycle_count <= cycle_count + 1'b1;
            end
        end
    end

    // HB1 and HB2 are ignored by sinks and sent as zero.
    assign header = {8'd0, 8'd0, acr_pkg::ACR_PACKET_TYPE};

    // SB0 sits in the low byte.
    assign sub_packet = {N[7:0], N[15:8], 4'd0, N[19:16],
                         cts[7:0], cts[15:8], 4'd0, cts[19:16], 8'd0};

endmodule

/* hdl/packet_ecc.sv */
`timescale 1ns/1ps
// packet_ecc
// appends the data island BCH parity byte to the header and subpacket
// and registers both codewords.
module packet_ecc
(
    input  logic clk_pixel,
    input  logic rst,
    input  logic [acr_pkg::HEADER_BITS-1:0] header,
    input  logic [acr_pkg::SUBPACKET_BITS-1:0] sub_packet,
    input  logic cts_update,
    output logic [acr_pkg::HEADER_CODE_BITS-1:0] header_code,
    output logic [acr_pkg::SUBPACKET_CODE_BITS-1:0] sub_code,
    output logic code_valid
);
    // generator 1 + x^6 + x^7 + x^8, lsb first.
    function automatic logic [acr_pkg::ECC_BITS-1:0] bch_parity(
        input logic [acr_pkg::SUBPACKET_BITS-1:0] data,
        input int len
    );
        logic [acr_pkg::ECC_BITS-1:0] ecc;
        logic feedback;
        ecc = '0;
        for (int i = 0; i < len; i++)
        begin
            feedback = ecc[0] ^ data[i];
            ecc = (ecc >> 1) ^ (feedback ? 8'h83 : 8'h00);
        end
        return ecc;
    endfunction

    logic [acr_pkg::ECC_BITS-1:0] header_parity;
    logic [acr_pkg::ECC_BITS-1:0] sub_parity;

    assign header_parity = bch_parity(acr_pkg::SUBPACKET_BITS'(header), acr_pkg::HEADER_BITS);
    assign sub_parity = bch_parity(sub_packet, acr_pkg::SUBPACKET_BITS);

    always_ff @(posedge clk_pixel)
    begin
        header_code <= {header_parity, header};         // parity in the top byte.
        sub_code <= {sub_parity, sub_packet};
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            code_valid <= 1'b0;
        end
        else
        begin
            code_valid <= cts_update;                   // aligned with the codewords.
        end
    end

endmodule

/* hdl/island_serializer.sv */
`timescale 1ns/1ps
// island_serializer
// keeps the latest packet pending and shifts it out in data island bit
// order over 32 pixel clocks.
module island_serializer
(
    input  logic clk_pixel,
    input  logic rst,
    input  logic send_enable,
    input  logic [acr_pkg::HEADER_CODE_BITS-1:0] header_code,
    input  logic [acr_pkg::SUBPACKET_CODE_BITS-1:0] sub_code,
    input  logic code_valid,
    output logic island_active,
    output logic island_header_bit,
    output logic [3:0] island_ch1,
    output logic [3:0] island_ch2,
    output logic packet_done
);
    localparam logic [4:0] LAST_CYCLE = 5'(acr_pkg::ISLAND_CYCLES - 1);

    logic [acr_pkg::HEADER_CODE_BITS-1:0] header_store;
    logic [acr_pkg::SUBPACKET_CODE_BITS-1:0] sub_store;
    logic [acr_pkg::HEADER_CODE_BITS-1:0] header_shift;
    logic [acr_pkg::SUBPACKET_CODE_BITS-1:0] sub_shift;
    logic pending;
    logic load;
    logic [4:0] bit_count;

    assign load = pending & ~island_active & send_enable;

    // newest packet wins.
    always_ff @(posedge clk_pixel)
    begin
        if (code_valid)
        begin
            header_store <= header_code;
            sub_store <= sub_code;
        end
        if (load)
        begin
            header_shift <= header_store;
            sub_shift <= sub_store;
        end
        else if (island_active)
        begin
            header_shift <= header_shift >> 1;
            sub_shift <= sub_shift >> 2;                // two bits per lane each cycle.
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            pending <= 1'b0;
            island_active <= 1'b0;
            bit_count <= '0;
        end
        else
        begin
            if (code_valid)
                pending <= 1'b1;
            else if (load)
                pending <= 1'b0;

            if (load)
            begin
                island_active <= 1'b1;
                bit_count <= '0;
            end
            else if (island_active)
            begin
                bit_count <= bit_count + 1'b1;
                if (bit_count == LAST_CYCLE)
                    island_active <= 1'b0;
            end
        end
    end

    // the four subpackets share one codeword.
    assign island_header_bit = island_active & header_shift[0];
    assign island_ch1 = {4{island_active & sub_shift[0]}};
    assign island_ch2 = {4{island_active & sub_shift[1]}};
    assign packet_done = island_active & (bit_count == LAST_CYCLE);

endmodule

/* hdl/acr_wb_regs.sv */
`timescale 1ns/1ps
// acr_wb_regs
// Wishbone classic slave with the send enable, last CTS and sent packet count.
module acr_wb_regs
(
    input  logic clk_pixel,
    input  logic rst,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [acr_pkg::WB_ADDR_BITS-1:0] wb_adr,
    input  logic [acr_pkg::WB_DATA_BITS-1:0] wb_dat_w,
    output logic [acr_pkg::WB_DATA_BITS-1:0] wb_dat_r,
    output logic wb_ack,
    input  logic [19:0] cts,
    input  logic packet_done,
    output logic send_enable
);
    logic request;
    logic [31:0] packet_count;

    assign request = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
            send_enable <= 1'b0;
            packet_count <= '0;
        end
        else
        begin
            wb_ack <= request;                          // single-cycle ack.
            if (request && wb_we && wb_adr == acr_pkg::REG_CTRL)
                send_enable <= wb_dat_w[0];
            if (packet_done)
                packet_count <= packet_count + 1'b1;    // wraps.
        end
    end

    // read data lines up with ack.
    always_ff @(posedge clk_pixel)
    begin
        if (request && !wb_we)
        begin
            case (wb_adr)
                acr_pkg::REG_CTRL:  wb_dat_r <= {31'd0, send_enable};
                acr_pkg::REG_CTS:   wb_dat_r <= {12'd0, cts};
                acr_pkg::REG_COUNT: wb_dat_r <= packet_count;
                default:            wb_dat_r <= '0;
            endcase
        end
    end

endmodule

/* hdl/acr_island_top.sv */
`timescale 1ns/1ps
// acr_island_top
// ACR packet source, BCH encoder, island serializer and Wishbone registers.
module acr_island_top
#(
    parameter real VIDEO_RATE = 74.25e6,
    parameter int AUDIO_RATE = 48000
)
(
    input  logic clk_pixel,
    input  logic clk_audio,
    input  logic rst,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [acr_pkg::WB_ADDR_BITS-1:0] wb_adr,
    input  logic [acr_pkg::WB_DATA_BITS-1:0] wb_dat_w,
    output logic [acr_pkg::WB_DATA_BITS-1:0] wb_dat_r,
    output logic wb_ack,
    output logic island_active,
    output logic island_header_bit,
    output logic [3:0] island_ch1,
    output logic [3:0] island_ch2
);
    logic [acr_pkg::HEADER_BITS-1:0] header;
    logic [acr_pkg::SUBPACKET_BITS-1:0] sub_packet;
    logic [19:0] cts;
    logic cts_update;
    logic [acr_pkg::HEADER_CODE_BITS-1:0] header_code;
    logic [acr_pkg::SUBPACKET_CODE_BITS-1:0] sub_code;
    logic code_valid;
    logic send_enable;
    logic packet_done;

    acr_packet #(
        .VIDEO_RATE (VIDEO_RATE),
        .AUDIO_RATE (AUDIO_RATE)
    ) u_acr_packet (
        .clk_pixel  (clk_pixel),
        .clk_audio  (clk_audio),
        .rst        (rst),
        .header     (header),
        .sub_packet (sub_packet),
        .cts        (cts),
        .cts_update (cts_update)
    );

    packet_ecc u_packet_ecc (
        .clk_pixel   (clk_pixel),
        .rst         (rst),
        .header      (header),
        .sub_packet  (sub_packet),
        .cts_update  (cts_update),
        .header_code (header_code),
        .sub_code    (sub_code),
        .code_valid  (code_valid)
    );

    island_serializer u_island_serializer (
        .clk_pixel         (clk_pixel),
        .rst               (rst),
        .send_enable       (send_enable),
        .header_code       (header_code),
        .sub_code          (sub_code),
        .code_valid        (code_valid),
        .island_active     (island_active),
        .island_header_bit (island_header_bit),
        .island_ch1        (island_ch1),
        .island_ch2        (island_ch2),
        .packet_done       (packet_done)
    );

    acr_wb_regs u_acr_wb_regs (
        .clk_pixel   (clk_pixel),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .cts         (cts),
        .packet_done (packet_done),
        .send_enable (send_enable)
    );

endmodule

/* test/tb_acr_island.sv */
`timescale 1ns/1ps
// tb_acr_island
// drives the ACR island path and checks every island against reference values.
module tb_acr_island;

    localparam int AUDIO_RATE = 48000;
    localparam real PIXEL_PERIOD = 100.0;
    localparam real AUDIO_PERIOD = 20833.0;
    localparam int WRAP_SAMPLES = 48;                   // N / 128 for 48 kHz.
    localparam logic [19:0] N_VALUE = 20'd6144;

    logic clk_pixel;
    logic clk_audio;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [acr_pkg::WB_ADDR_BITS-1:0] wb_adr;
    logic [acr_pkg::WB_DATA_BITS-1:0] wb_dat_w;
    logic [acr_pkg::WB_DATA_BITS-1:0] wb_dat_r;
    logic wb_ack;
    logic island_active;
    logic island_header_bit;
    logic [3:0] island_ch1;
    logic [3:0] island_ch2;

    logic [31:0] cap_header;
    logic [63:0] cap_sub [4];
    int bit_index = 0;
    int island_count = 0;
    int cycle_count = 0;
    logic [19:0] last_cts = '0;

    acr_island_top #(
        .VIDEO_RATE (10e6),
        .AUDIO_RATE (AUDIO_RATE)
    ) UUT (
        .clk_pixel         (clk_pixel),
        .clk_audio         (clk_audio),
        .rst               (rst),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_we             (wb_we),
        .wb_adr            (wb_adr),
        .wb_dat_w          (wb_dat_w),
        .wb_dat_r          (wb_dat_r),
        .wb_ack            (wb_ack),
        .island_active     (island_active),
        .island_header_bit (island_header_bit),
        .island_ch1        (island_ch1),
        .island_ch2        (island_ch2)
    );

    initial
    begin
        clk_pixel = 1'b0;
        forever #(PIXEL_PERIOD / 2.0) clk_pixel = ~clk_pixel;
    end

    initial
    begin
        clk_audio = 1'b0;
        forever #(AUDIO_PERIOD / 2.0) clk_audio = ~clk_audio;
    end

    // pixel clocks per wrap, rounded.
    function automatic int ref_cts();
        real wrap_ns;
        wrap_ns = real'(WRAP_SAMPLES) * AUDIO_PERIOD;
        return int'(wrap_ns / PIXEL_PERIOD);
    endfunction

    // BCH parity, g(x) = 1 + x^6 + x^7 + x^8, data lsb first.
    function automatic logic [7:0] ref_bch(input logic [55:0] data, input int len);
        logic [7:0] r;
        logic fb;
        r = 8'd0;
        for (int i = 0; i < len; i++)
        begin
            fb = r[0] ^ data[i];
            r = {fb, r[7], r[6], r[5], r[4], r[3], r[2] ^ fb, r[1] ^ fb};
        end
        return r;
    endfunction

    // SB0 first, then CTS and N with the high nibble in its own byte.
    function automatic logic [55:0] ref_subpacket(input logic [19:0] cts, input logic [19:0] n);
        logic [7:0] sb [7];
        logic [55:0] result;
        sb[0] = 8'd0;
        sb[1] = {4'd0, cts[19:16]};
        sb[2] = cts[15:8];
        sb[3] = cts[7:0];
        sb[4] = {4'd0, n[19:16]};
        sb[5] = n[15:8];
        sb[6] = n[7:0];
        for (int i = 0; i < 7; i++)
        begin
            result[8 * i +: 8] = sb[i];
        end
        return result;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s (time %0t)", reason, $time);
        $display("Regression failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // one captured island against the reference.
    task automatic check_island();
        logic [19:0] cts_field;
        int ideal;
        check_value(64'(bit_index), 64'd32, "island length");
        check_value(64'(cap_header[23:0]), 64'h000001, "header bytes");
        check_value(64'(cap_header[31:24]), 64'(ref_bch(56'(cap_header[23:0]), 24)),
                    "header parity");
        for (int lane = 1; lane < 4; lane++)
        begin
            check_value(cap_sub[lane], cap_sub[0], "subpackets identical");
        end
        cts_field = {cap_sub[0][11:8], cap_sub[0][23:16], cap_sub[0][31:24]};
        ideal = ref_cts();
        check_value(64'(int'(cts_field) >= ideal - 1 && int'(cts_field) <= ideal + 1), 64'd1,
                    "cts field within one of reference");
        check_value(64'(cap_sub[0][55:0]), 64'(ref_subpacket(cts_field, N_VALUE)),
                    "subpacket fields");
        check_value(64'(cap_sub[0][63:56]), 64'(ref_bch(cap_sub[0][55:0], 56)),
                    "subpacket parity");
        last_cts = cts_field;
        island_count++;
    endtask

    // island capture, sampled mid-cycle.
    always @(negedge clk_pixel)
    begin
        if (island_active)
        begin
            check_value(64'(bit_index < 32), 64'd1, "island no longer than 32 cycles");
            cap_header[bit_index] = island_header_bit;
            for (int lane = 0; lane < 4; lane++)
            begin
                cap_sub[lane][2 * bit_index] = island_ch1[lane];
                cap_sub[lane][2 * bit_index + 1] = island_ch2[lane];
            end
            bit_index++;
        end
        else if (bit_index != 0)
        begin
            check_island();
            bit_index = 0;
        end
    end

    always @(posedge clk_pixel)
    begin
        cycle_count++;
        if (cycle_count > 8 * ref_cts() + 2000)
            abort_run("timeout, the run went past its cycle limit");
    end

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int wait_cycles;
        wait_cycles = 0;
        @(posedge clk_pixel);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        while (!wb_ack)
        begin
            @(posedge clk_pixel);
            #1;
            wait_cycles++;
        end
        check_value(64'(wait_cycles), 64'd1, "wishbone ack latency");
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        repeat ($urandom_range(4, 1)) @(posedge clk_pixel);     // idle gap.
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    initial
    begin
        logic [31:0] value;
        int count_before;
        void'($urandom(98));
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge clk_pixel);
        #1;
        rst = 1'b0;

        // disabled, CTS still measured.
        repeat (2 * ref_cts() + 5000) @(posedge clk_pixel);
        check_value(64'(island_count), 64'd0, "no island while disabled");
        wb_read(acr_pkg::REG_CTS, value);
        check_value(64'(value != 0), 64'd1, "cts measured while disabled");

        wb_write(acr_pkg::REG_CTRL, 32'd1);
        while (island_count < 3)
            @(posedge clk_pixel);
        wb_read(acr_pkg::REG_CTS, value);
        check_value(64'(value), 64'(last_cts), "REG_CTS against last island");
        wb_read(acr_pkg::REG_COUNT, value);
        check_value(64'(value), 64'(island_count), "REG_COUNT against monitor");
        wb_write(acr_pkg::REG_COUNT, 32'hdead_beef);
        wb_read(acr_pkg::REG_COUNT, value);
        check_value(64'(value), 64'(island_count), "REG_COUNT after write");

        // clear the enable in the middle of an island.
        @(posedge island_active);
        wb_write(acr_pkg::REG_CTRL, 32'd0);
        @(negedge island_active);
        repeat (2) @(posedge clk_pixel);
        check_value(64'(island_count), 64'd4, "island completes after disable");
        count_before = island_count;
        repeat (ref_cts() * 3 / 2) @(posedge clk_pixel);
        check_value(64'(island_count), 64'(count_before), "no island after disable");
        check_value(64'(island_active), 64'd0, "island_active low after disable");

        $display("Regression passed");
        $finish;
    end

endmodule

/* compile.f */
hdl/acr_pkg.sv
hdl/acr_packet.sv
hdl/packet_ecc.sv
hdl/island_serializer.sv
hdl/acr_wb_regs.sv
hdl/acr_island_top.sv
test/tb_acr_island.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ACR island testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_acr_island -f compile.f -o Vtb_acr_island

# the log decides the result.
./obj_dir/Vtb_acr_island | tee sim.log

if grep -q "Regression passed" sim.log
then
    echo "simulation ok"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
